//--- logic/conv_pkg.sv
package conv_pkg;

    ////////////////////////////////////////////////
    // basic types
    ////////////////////////////////////////////////

    // row, column, size or buffer word address
    typedef logic [15:0] coord_t;

    // lane has no valid input row
    localparam coord_t NO_ROW = 16'hffff;

    ////////////////////////////////////////////////
    // row buffering
    ////////////////////////////////////////////////

    // ring of row buffers, one per output row lane
    localparam int BUF_NUM = 3;

    // output rows handled per group
    localparam int LANES = 3;

    ////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////

    // FLUSH lets the last step leave the datapath before busy drops
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FLUSH
    } seq_state_t;

endpackage

//--- logic/conv_step_if.sv
`timescale 1ns/1ps

interface conv_step_if import conv_pkg::*; ();

    // loop position
    coord_t     oy_start;
    coord_t     ox_start;
    logic [3:0] idx_in_k;

    // output size of the layer
    coord_t     ox;
    coord_t     oy;

    // one-cycle strobe, position valid now
    logic       fire;
    // final position of the layer
    logic       last;

    modport seq (
        output oy_start, ox_start, idx_in_k,
        output ox, oy,
        output fire, last
    );

    modport dp (
        input oy_start, ox_start, idx_in_k,
        input ox, oy,
        input fire, last
    );

endinterface

//--- logic/conv_sequencer.sv
`timescale 1ns/1ps

module conv_sequencer import conv_pkg::*; #(
    parameter int pixels_in_row = 32
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       start,
    input  logic       en,
    input  coord_t     ix,
    input  coord_t     iy,
    input  logic [3:0] k,
    input  logic [3:0] s,
    input  logic [3:0] p,
    conv_step_if.seq   step,
    output logic       busy
);

    localparam coord_t SLAB_STEP = coord_t'(pixels_in_row);
    localparam coord_t ROW_STEP  = coord_t'(LANES);

    seq_state_t state;

    coord_t     ox_c;
    coord_t     oy_c;
    coord_t     ox_start_q;
    coord_t     oy_start_q;
    logic [3:0] idx_q;

    logic fire;
    logic k_last;
    logic x_last;
    logic y_last;
    logic last;

    ////////////////////////////////////////////////
    // output size
    ////////////////////////////////////////////////

    // stride is 1 or 2, so the divide is a shift by s-1
    assign ox_c = ((ix + (coord_t'(p) << 1) - coord_t'(k)) >> (s - 4'd1)) + 16'd1;
    assign oy_c = ((iy + (coord_t'(p) << 1) - coord_t'(k)) >> (s - 4'd1)) + 16'd1;

    ////////////////////////////////////////////////
    // loop end detection
    ////////////////////////////////////////////////

    assign k_last = (idx_q == k - 4'd1);
    // remaining width fits in this slab
    assign x_last = ((ox_c - ox_start_q) <= SLAB_STEP);
    // remaining rows fit in this group
    assign y_last = ((oy_c - oy_start_q) <= ROW_STEP);
    assign last   = k_last && x_last && y_last;

    // en low freezes the walk
    assign fire = (state == RUN) && en;
    assign busy = (state != IDLE);

    ////////////////////////////////////////////////
    // state and counters
    ////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            idx_q      <= '0;
            ox_start_q <= '0;
            oy_start_q <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (start) begin
                        state      <= RUN;
                        idx_q      <= '0;
                        ox_start_q <= '0;
                        oy_start_q <= '0;
                    end
                end
                RUN: begin
                    if (fire) begin
                        // kernel row innermost, then slab, then row group
                        if (!k_last) begin
                            idx_q <= idx_q + 4'd1;
                        end else begin
                            idx_q <= '0;
                            if (!x_last) begin
                                ox_start_q <= ox_start_q + SLAB_STEP;
                            end else begin
                                ox_start_q <= '0;
                                oy_start_q <= oy_start_q + ROW_STEP;
                            end
                        end
                        if (last) begin
                            state <= FLUSH;
                        end
                    end
                end
                FLUSH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign step.oy_start = oy_start_q;
    assign step.ox_start = ox_start_q;
    assign step.idx_in_k = idx_q;
    assign step.ox       = ox_c;
    assign step.oy       = oy_c;
    assign step.fire     = fire;
    assign step.last     = last;

endmodule

//--- logic/conv_row_lane.sv
`timescale 1ns/1ps

module conv_row_lane import conv_pkg::*; #(
    parameter int lane_id = 0
) (
    input  logic       clk,
    input  logic       arst_n,
    conv_step_if.dp    step,
    input  coord_t     iy,
    input  logic [3:0] s,
    input  logic [3:0] p,
    input  logic [3:0] row_pitch_log2,
    input  coord_t     row_start_idx,
    output coord_t     row_idx,
    output coord_t     buf_adr,
    output logic [1:0] buf_idx
);

    localparam coord_t RING = coord_t'(BUF_NUM);

    // wide signed copies, the input row may go below zero
    logic signed [19:0] out_row;
    logic signed [19:0] in_row;
    logic signed [19:0] oy_s;
    logic signed [19:0] iy_s;
    logic signed [19:0] s_s;
    logic signed [19:0] p_s;
    logic signed [19:0] idx_s;

    logic       row_ok;
    coord_t     row_c;
    coord_t     adr_c;
    logic [1:0] buf_c;

    assign out_row = 20'(step.oy_start) + 20'(lane_id);
    assign oy_s    = 20'(step.oy);
    assign iy_s    = 20'(iy);
    assign s_s     = 20'(s);
    assign p_s     = 20'(p);
    assign idx_s   = 20'(step.idx_in_k);

    assign in_row = out_row * s_s + idx_s - p_s;

    // lane past the last output row, or a padding row
    assign row_ok = (out_row < oy_s) && (in_row >= 20'sd0) && (in_row < iy_s);

    assign row_c = row_ok ? coord_t'(in_row) : NO_ROW;

    ////////////////////////////////////////////////
    // ring buffer mapping
    ////////////////////////////////////////////////

    // row r sits in buffer r mod 3 at line r / 3
    assign buf_c = row_ok ? 2'(row_c % RING) : 2'd0;
    assign adr_c = row_ok ? ((row_c / RING) << row_pitch_log2) + row_start_idx : NO_ROW;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            row_idx <= NO_ROW;
            buf_idx <= 2'd0;
            buf_adr <= NO_ROW;
        end else if (step.fire) begin
            row_idx <= row_c;
            buf_idx <= buf_c;
            buf_adr <= adr_c;
        end
    end

endmodule

//--- logic/conv_slab_span.sv
`timescale 1ns/1ps

module conv_slab_span import conv_pkg::*; #(
    parameter int pixels_in_row = 32
) (
    input  logic       clk,
    input  logic       arst_n,
    conv_step_if.dp    step,
    input  coord_t     ix,
    input  logic [3:0] k,
    input  logic [3:0] s,
    input  logic [3:0] p,
    output coord_t     row_start_idx_c,
    output logic [3:0] west_pad,
    output logic [3:0] east_pad,
    output coord_t     slab_num,
    output coord_t     row_start_idx,
    output coord_t     row_end_idx,
    output logic       step_valid,
    output logic       conv_end
);

    localparam coord_t SLAB_MAX = coord_t'(pixels_in_row);

    coord_t remain;
    coord_t slab_c;
    coord_t end_c;

    logic [3:0] west_c;
    logic [3:0] east_c;

    logic signed [19:0] ox_start_s;
    logic signed [19:0] slab_s;
    logic signed [19:0] s_s;
    logic signed [19:0] k_s;
    logic signed [19:0] p_s;
    logic signed [19:0] ix_last;
    logic signed [19:0] left_col;
    logic signed [19:0] right_col;

    // last slab of a row may be partial
    assign remain = step.ox - step.ox_start;
    assign slab_c = (remain < SLAB_MAX) ? remain : SLAB_MAX;

    assign ox_start_s = 20'(step.ox_start);
    assign slab_s     = 20'(slab_c);
    assign s_s        = 20'(s);
    assign k_s        = 20'(k);
    assign p_s        = 20'(p);
    assign ix_last    = 20'(ix) - 20'sd1;

    ////////////////////////////////////////////////
    // input column span of the slab
    ////////////////////////////////////////////////

    assign left_col  = ox_start_s * s_s - p_s;
    assign right_col = (ox_start_s + slab_s - 20'sd1) * s_s + k_s - 20'sd1 - p_s;

    assign west_c          = (left_col < 20'sd0) ? 4'(-left_col) : 4'd0;
    assign row_start_idx_c = (left_col < 20'sd0) ? '0 : coord_t'(left_col);

    assign east_c = (right_col > ix_last) ? 4'(right_col - ix_last) : 4'd0;
    assign end_c  = (right_col > ix_last) ? coord_t'(ix_last) : coord_t'(right_col);

    // strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            step_valid <= 1'b0;
            conv_end   <= 1'b0;
        end else begin
            step_valid <= step.fire;
            conv_end   <= step.fire && step.last;
        end
    end

    // slab geometry, held between steps
    always_ff @(posedge clk) begin
        if (step.fire) begin
            west_pad      <= west_c;
            east_pad      <= east_c;
            slab_num      <= slab_c;
            row_start_idx <= row_start_idx_c;
            row_end_idx   <= end_c;
        end
    end

endmodule

//--- logic/conv_router.sv
`timescale 1ns/1ps

module conv_router import conv_pkg::*; #(
    parameter int pixels_in_row = 32
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       start,
    input  logic       en,
    input  coord_t     ix,
    input  coord_t     iy,
    input  logic [3:0] k,
    input  logic [3:0] s,
    input  logic [3:0] p,
    input  logic [3:0] row_pitch_log2,
    output logic       busy,
    output logic       step_valid,
    output logic       conv_end,
    output coord_t     row1_idx,
    output coord_t     row2_idx,
    output coord_t     row3_idx,
    output logic [1:0] row1_buf_idx,
    output logic [1:0] row2_buf_idx,
    output logic [1:0] row3_buf_idx,
    output coord_t     row1_buf_adr,
    output coord_t     row2_buf_adr,
    output coord_t     row3_buf_adr,
    output logic [3:0] west_pad,
    output logic [3:0] east_pad,
    output coord_t     slab_num,
    output coord_t     row_start_idx,
    output coord_t     row_end_idx
);

    // slab start column, same cycle as fire
    coord_t start_col;

    conv_step_if step ();

    ////////////////////////////////////////////////
    // loop control
    ////////////////////////////////////////////////

    conv_sequencer #(
        .pixels_in_row (pixels_in_row)
    ) u_seq (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .en     (en),
        .ix     (ix),
        .iy     (iy),
        .k      (k),
        .s      (s),
        .p      (p),
        .step   (step.seq),
        .busy   (busy)
    );

    ////////////////////////////////////////////////
    // slab geometry
    ////////////////////////////////////////////////

    conv_slab_span #(
        .pixels_in_row (pixels_in_row)
    ) u_span (
        .clk             (clk),
        .arst_n          (arst_n),
        .step            (step.dp),
        .ix              (ix),
        .k               (k),
        .s               (s),
        .p               (p),
        .row_start_idx_c (start_col),
        .west_pad        (west_pad),
        .east_pad        (east_pad),
        .slab_num        (slab_num),
        .row_start_idx   (row_start_idx),
        .row_end_idx     (row_end_idx),
        .step_valid      (step_valid),
        .conv_end        (conv_end)
    );

    ////////////////////////////////////////////////
    // row lanes
    ////////////////////////////////////////////////

    conv_row_lane #(.lane_id(0)) u_lane1 (
        .clk            (clk),
        .arst_n         (arst_n),
        .step           (step.dp),
        .iy             (iy),
        .s              (s),
        .p              (p),
        .row_pitch_log2 (row_pitch_log2),
        .row_start_idx  (start_col),
        .row_idx        (row1_idx),
        .buf_adr        (row1_buf_adr),
        .buf_idx        (row1_buf_idx)
    );

    conv_row_lane #(.lane_id(1)) u_lane2 (
        .clk            (clk),
        .arst_n         (arst_n),
        .step           (step.dp),
        .iy             (iy),
        .s              (s),
        .p              (p),
        .row_pitch_log2 (row_pitch_log2),
        .row_start_idx  (start_col),
        .row_idx        (row2_idx),
        .buf_adr        (row2_buf_adr),
        .buf_idx        (row2_buf_idx)
    );

    conv_row_lane #(.lane_id(2)) u_lane3 (
        .clk            (clk),
        .arst_n         (arst_n),
        .step           (step.dp),
        .iy             (iy),
        .s              (s),
        .p              (p),
        .row_pitch_log2 (row_pitch_log2),
        .row_start_idx  (start_col),
        .row_idx        (row3_idx),
        .buf_adr        (row3_buf_adr),
        .buf_idx        (row3_buf_idx)
    );

endmodule

//--- verif/conv_router_model.svh
`ifndef CONV_ROUTER_MODEL_SVH
`define CONV_ROUTER_MODEL_SVH

// one layer of the stimulus table
typedef struct packed {
    coord_t     ix;
    coord_t     iy;
    logic [3:0] k;
    logic [3:0] s;
    logic [3:0] p;
    logic [3:0] pitch;
    logic       rand_en;
} layer_cfg_t;

// expected datapath outputs of one step
typedef struct packed {
    coord_t [2:0]     row;
    logic [2:0][1:0]  bufi;
    coord_t [2:0]     adr;
    logic [3:0]       west;
    logic [3:0]       east;
    coord_t           slab;
    coord_t           first_col;
    coord_t           last_col;
} step_exp_t;

function automatic int out_size(input int in_size, input int k, input int s, input int p);
    return (in_size + 2 * p - k) / s + 1;
endfunction

function automatic int step_total(input layer_cfg_t c, input int pix);
    int ox;
    int oy;
    ox = out_size(c.ix, c.k, c.s, c.p);
    oy = out_size(c.iy, c.k, c.s, c.p);
    // row groups of three, slabs of pix pixels, k kernel rows each
    return ((oy + 2) / 3) * ((ox + pix - 1) / pix) * int'(c.k);
endfunction

function automatic step_exp_t expected_step(input layer_cfg_t c, input int n, input int pix);
    step_exp_t e;
    int k;
    int s;
    int p;
    int ix;
    int iy;
    int ox;
    int oy;
    int nslab;
    int kn;
    int ox_start;
    int oy_start;
    int slab;
    int left;
    int right;
    int orow;
    int irow;
    k  = c.k;
    s  = c.s;
    p  = c.p;
    ix = c.ix;
    iy = c.iy;
    ox = out_size(ix, k, s, p);
    oy = out_size(iy, k, s, p);
    nslab = (ox + pix - 1) / pix;
    // kernel row innermost, then slab, then row group
    kn       = n % k;
    ox_start = ((n / k) % nslab) * pix;
    oy_start = ((n / k) / nslab) * 3;
    slab  = (ox - ox_start < pix) ? ox - ox_start : pix;
    left  = ox_start * s - p;
    right = (ox_start + slab - 1) * s + k - 1 - p;
    e.slab      = coord_t'(slab);
    e.west      = (left < 0) ? 4'(-left) : 4'd0;
    e.first_col = (left < 0) ? 16'd0 : coord_t'(left);
    e.east      = (right > ix - 1) ? 4'(right - ix + 1) : 4'd0;
    e.last_col  = (right > ix - 1) ? coord_t'(ix - 1) : coord_t'(right);
    for (int lane = 0; lane < 3; lane++) begin
        orow = oy_start + lane;
        irow = orow * s + kn - p;
        if (orow < oy && irow >= 0 && irow < iy) begin
            e.row[lane]  = coord_t'(irow);
            e.bufi[lane] = 2'(irow % 3);
            e.adr[lane]  = coord_t'(((irow / 3) << c.pitch) + int'(e.first_col));
        end else begin
            e.row[lane]  = NO_ROW;
            e.bufi[lane] = 2'd0;
            e.adr[lane]  = 16'hffff;
        end
    end
    return e;
endfunction

`endif

//--- verif/conv_router_tb.sv
`timescale 1ns/1ps

module conv_router_tb import conv_pkg::*; ();

    `include "conv_router_model.svh"

    localparam int PIXELS = 32;
    localparam int LAYER_NUM = 6;

    logic       clk;
    logic       arst_n;
    logic       start;
    logic       en;
    coord_t     ix;
    coord_t     iy;
    logic [3:0] k;
    logic [3:0] s;
    logic [3:0] p;
    logic [3:0] row_pitch_log2;

    logic       busy;
    logic       step_valid;
    logic       conv_end;
    coord_t     row1_idx;
    coord_t     row2_idx;
    coord_t     row3_idx;
    logic [1:0] row1_buf_idx;
    logic [1:0] row2_buf_idx;
    logic [1:0] row3_buf_idx;
    coord_t     row1_buf_adr;
    coord_t     row2_buf_adr;
    coord_t     row3_buf_adr;
    logic [3:0] west_pad;
    logic [3:0] east_pad;
    coord_t     slab_num;
    coord_t     row_start_idx;
    coord_t     row_end_idx;

    layer_cfg_t layers [LAYER_NUM];
    layer_cfg_t cur;
    step_exp_t  exp_step;

    integer seed;
    integer rnd;
    integer errors;
    integer checks;
    integer step_n;
    integer total;
    integer end_count;
    integer limit_ns;
    logic   rand_en;
    logic   end_prev;

    conv_router #(.pixels_in_row(PIXELS)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("** Error @ %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    function automatic layer_cfg_t make_layer(input int lx, input int ly, input int lk,
                                              input int ls, input int lp, input int pitch,
                                              input bit random_en);
        layer_cfg_t c;
        c.ix      = coord_t'(lx);
        c.iy      = coord_t'(ly);
        c.k       = 4'(lk);
        c.s       = 4'(ls);
        c.p       = 4'(lp);
        c.pitch   = 4'(pitch);
        c.rand_en = random_en;
        return c;
    endfunction

    task automatic run_layer(input layer_cfg_t c);
        @(posedge clk);
        cur       = c;
        total     = step_total(c, PIXELS);
        step_n    = 0;
        end_count = 0;
        ix             <= c.ix;
        iy             <= c.iy;
        k              <= c.k;
        s              <= c.s;
        p              <= c.p;
        row_pitch_log2 <= c.pitch;
        rand_en        <= c.rand_en;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (!(step_n >= total && !busy && !end_prev)) begin
            @(posedge clk);
        end
        check_value("step count", total, step_n);
        check_value("conv_end pulses", 1, end_count);
    endtask

    // en duty is always on or random
    always @(posedge clk) begin
        if (rand_en) begin
            rnd = $random(seed);
            en <= rnd[0];
        end else begin
            en <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // step monitor
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (arst_n) begin
            // busy must be low one cycle after the end pulse
            if (end_prev) begin
                check_value("busy", 0, busy);
                end_prev = 1'b0;
            end
            if (step_valid) begin
                if (step_n >= total) begin
                    errors = errors + 1;
                    $display("step_valid seen at %0d ns after all %0d steps were done",
                             $time, total);
                end else begin
                    exp_step = expected_step(cur, step_n, PIXELS);
                    check_value("row1_idx", exp_step.row[0], row1_idx);
                    check_value("row2_idx", exp_step.row[1], row2_idx);
                    check_value("row3_idx", exp_step.row[2], row3_idx);
                    check_value("row1_buf_idx", exp_step.bufi[0], row1_buf_idx);
                    check_value("row2_buf_idx", exp_step.bufi[1], row2_buf_idx);
                    check_value("row3_buf_idx", exp_step.bufi[2], row3_buf_idx);
                    check_value("row1_buf_adr", exp_step.adr[0], row1_buf_adr);
                    check_value("row2_buf_adr", exp_step.adr[1], row2_buf_adr);
                    check_value("row3_buf_adr", exp_step.adr[2], row3_buf_adr);
                    check_value("west_pad", exp_step.west, west_pad);
                    check_value("east_pad", exp_step.east, east_pad);
                    check_value("slab_num", exp_step.slab, slab_num);
                    check_value("row_start_idx", exp_step.first_col, row_start_idx);
                    check_value("row_end_idx", exp_step.last_col, row_end_idx);
                    check_value("conv_end", (step_n == total - 1), conv_end);
                    check_value("busy", 1, busy);
                    if (conv_end) begin
                        end_count = end_count + 1;
                        end_prev  = 1'b1;
                    end
                end
                step_n = step_n + 1;
            end else begin
                check_value("conv_end", 0, conv_end);
            end
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        arst_n         = 1'b0;
        start          = 1'b0;
        en             = 1'b1;
        ix             = '0;
        iy             = '0;
        k              = 4'd1;
        s              = 4'd1;
        p              = 4'd0;
        row_pitch_log2 = 4'd0;
        rand_en        = 1'b0;
        end_prev       = 1'b0;
        seed           = 32'h1e27;
        errors         = 0;
        checks         = 0;
        step_n         = 0;
        total          = 0;
        end_count      = 0;
        cur            = '0;

        // ix, iy, k, s, p, pitch, random en
        layers[0] = make_layer(8, 8, 3, 1, 1, 4, 1'b0);
        layers[1] = make_layer(9, 7, 3, 2, 0, 3, 1'b0);
        layers[2] = make_layer(40, 5, 3, 1, 1, 6, 1'b0);
        layers[3] = make_layer(70, 10, 2, 2, 1, 5, 1'b0);
        layers[4] = make_layer(40, 5, 3, 1, 1, 6, 1'b1);
        layers[5] = make_layer(5, 4, 1, 1, 0, 2, 1'b1);

        // reset, idle checks and slack, then each layer's budget
        rnd = 40;
        for (int i = 0; i < LAYER_NUM; i++) begin
            rnd = rnd + (step_total(layers[i], PIXELS) * 4 + 20) * (layers[i].rand_en ? 2 : 1);
        end
        limit_ns = rnd * 4;

        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        // idle after reset
        repeat (3) begin
            @(negedge clk);
            check_value("busy", 0, busy);
            check_value("step_valid", 0, step_valid);
            check_value("conv_end", 0, conv_end);
            check_value("row1_idx", NO_ROW, row1_idx);
            check_value("row2_idx", NO_ROW, row2_idx);
            check_value("row3_idx", NO_ROW, row3_idx);
        end

        for (int i = 0; i < LAYER_NUM; i++) begin
            run_layer(layers[i]);
        end

        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("watchdog expired after %0d ns, the design hung before all steps were done",
                 limit_ns);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- list.f
+incdir+verif
logic/conv_pkg.sv
logic/conv_step_if.sv
logic/conv_sequencer.sv
logic/conv_row_lane.sv
logic/conv_slab_span.sv
logic/conv_router.sv
verif/conv_router_tb.sv

//--- Bender.yml
package:
  name: conv_router

sources:
  - logic/conv_pkg.sv
  - logic/conv_step_if.sv
  - logic/conv_sequencer.sv
  - logic/conv_row_lane.sv
  - logic/conv_slab_span.sv
  - logic/conv_router.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/conv_router_tb.sv
